// ==== project.f ====
+incdir+logic
logic/mgt_regs_pkg.sv
logic/ctrl_regs.sv
logic/status_capture.sv
logic/regport_readback.sv
logic/activity_stretch.sv
logic/mgt_ctrl_core.sv
testbench/tb_clk_gen.sv
testbench/tb_mgt_ctrl_core.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it, and judge the result from the log
rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module tb_mgt_ctrl_core -f project.f \
  && { ./obj_dir/Vtb_mgt_ctrl_core > sim.log 2>&1 \
       || echo "Simulator exited with an error, Test failed" >> sim.log; } \
  || { echo "Verilator build failed"; exit 1; }

cat sim.log

grep -q "Test failed" sim.log && { echo "Simulation FAILED"; exit 1; } \
  || { echo "Simulation passed"; exit 0; }

// ==== testbench/tb_mgt_ctrl_core.sv ====
// Self-checking testbench for the link control block, random stimulus against a reference model
`timescale 1ns/1ps
`include "mgt_regs_defines.svh"

module tb_mgt_ctrl_core;

  import mgt_regs_pkg::*;

  logic        bus_clk, bus_rst;
  logic        wr_req_i, rd_req_i, rd_resp_o;
  logic [13:0] wr_addr_i, rd_addr_i;
  logic [31:0] wr_data_i, rd_data_o, overruns_i, checksum_errors_i;
  logic [47:0] bist_samps_i, bist_errors_i;
  logic        channel_up_i, hard_err_i, soft_err_i, crit_err_i, gt_pll_lock_i;
  logic        qpll_reset_i, qpll_lock_i, qpll_refclk_lost_i, bist_locked_i;
  logic        tx_valid_i, tx_ready_i, rx_valid_i, rx_ready_i;
  logic        bist_gen_en_o, bist_loopback_en_o, phy_areset_o, link_up_o, activity_o;
  logic [5:0]  bist_gen_rate_o;
  int          errors, checks, tests;

  tb_clk_gen clk_gen_i (.bus_clk(bus_clk), .bus_rst(bus_rst));

  mgt_ctrl_core #(.REG_BASE(14'h0), .PORTNUM(8'd5)) dut_i (.*);

  // ----------------------------------------
  // Compare tasks
  // ----------------------------------------
  task automatic check_word(input string what, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED at %0t: %s read %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_mac_status(input string what, input mac_status_u got,
                                  input mac_status_u exp);
    checks++;
    if (got.raw !== exp.raw) begin
      errors++;
      $display("CHECK FAILED at %0t: %s read %h, expected %h", $time, what, got.raw, exp.raw);
    end
  endtask

  task automatic check_ctrl(input string what, input mac_ctrl_u got, input mac_ctrl_u exp);
    checks++;
    if (got.raw !== exp.raw) begin
      errors++;
      $display("CHECK FAILED at %0t: %s outputs %h, expected %h", $time, what, got.raw, exp.raw);
    end
  endtask

  task automatic check_level(input string what, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED at %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  // Reference model
  function automatic logic [31:0] port_info_word(input logic link, input logic act);
    return {8'h01, 6'h00, act, link, 8'h03, 8'h05};
  endfunction

  // Status word with the checker idle, so lock latency is zero
  function automatic mac_status_u model_status(input logic crit);
    mac_status_u s;
    s.raw                = '0;
    s.f.channel_up       = channel_up_i;
    s.f.hard_err         = hard_err_i;
    s.f.soft_err         = soft_err_i;
    s.f.bist_locked      = bist_locked_i;
    s.f.qpll_reset       = qpll_reset_i;
    s.f.qpll_lock        = qpll_lock_i;
    s.f.qpll_refclk_lost = qpll_refclk_lost_i;
    s.f.gt_pll_lock      = gt_pll_lock_i;
    s.f.const_one        = 1'b1;
    s.f.crit_err         = crit;
    return s;
  endfunction

  // PHY status holds the raw link levels in its two low bits
  function automatic logic [31:0] model_phy_status();
    logic [31:0] w;
    w    = '0;
    w[0] = channel_up_i;
    w[1] = hard_err_i;
    return w;
  endfunction

  // ----------------------------------------
  // Bus helpers
  // ----------------------------------------
  task automatic write_reg(input logic [13:0] addr, input logic [31:0] data);
    @(posedge bus_clk);
    wr_req_i  <= 1'b1;
    wr_addr_i <= addr;
    wr_data_i <= data;
    @(posedge bus_clk);
    wr_req_i  <= 1'b0;
  endtask

  task automatic read_reg(input logic [13:0] addr, input bit want,
                          output logic [31:0] data, output bit got);
    int n;
    @(posedge bus_clk);
    rd_req_i  <= 1'b1;
    rd_addr_i <= addr;
    @(posedge bus_clk);
    rd_req_i  <= 1'b0;
    got  = 1'b0;
    data = '0;
    for (n = 0; n < 10 && !got; n++) begin   // Response timeout
      @(negedge bus_clk);
      if (rd_resp_o) begin
        got  = 1'b1;
        data = rd_data_o;
      end
    end
    if (want && !got) begin
      errors++;
      $display("No read response from address %h within 10 cycles", addr);
    end else if (!want && got) begin
      errors++;
      $display("Unmapped address %h returned a read response", addr);
    end
  endtask

  task automatic settle();
    repeat (4) @(posedge bus_clk);
  endtask

  task automatic report_test(input string name, input int err_before);
    tests++;
    $display("[%s] %s with %0d errors", name, (errors == err_before) ? "passed" : "FAILED",
             errors - err_before);
  endtask

  // ----------------------------------------
  // Tests
  // ----------------------------------------
  task automatic port_info_readback();
    int          e0;
    logic [31:0] d;
    bit          ok;
    e0 = errors;
    settle();
    read_reg(`MGT_REG_PORT_INFO, 1'b1, d, ok);
    if (ok) check_word("port info, link down", d, port_info_word(1'b0, 1'b0));
    check_level("link_up_o, link down", link_up_o, 1'b0);
    @(posedge bus_clk);
    channel_up_i <= 1'b1;
    settle();
    read_reg(`MGT_REG_PORT_INFO, 1'b1, d, ok);
    if (ok) check_word("port info, link up", d, port_info_word(1'b1, 1'b0));
    check_level("link_up_o, link up", link_up_o, 1'b1);
    report_test("port info", e0);
  endtask

  task automatic mac_ctrl_writes();
    int          e0, i;
    logic [31:0] w, last;
    logic [13:0] addr;
    mac_ctrl_u   g, x;
    e0   = errors;
    last = '0;
    for (i = 0; i < 24; i++) begin
      w = $urandom;
      if ($urandom % 3 != 0) begin
        write_reg(`MGT_REG_MAC_CTRL_STATUS, w);
        last = w;
      end else begin
        addr = 14'($urandom);
        if (addr == `MGT_REG_MAC_CTRL_STATUS) addr = 14'h8;
        write_reg(addr, w);   // Must be ignored
      end
      @(negedge bus_clk);
      x.raw = '0;
      x.f.bist_gen_en      = last[1];
      x.f.bist_loopback_en = last[2];
      x.f.bist_gen_rate    = last[8:3];
      x.f.phy_areset       = last[9];
      g.raw = '0;
      g.f.bist_gen_en      = bist_gen_en_o;
      g.f.bist_loopback_en = bist_loopback_en_o;
      g.f.bist_gen_rate    = bist_gen_rate_o;
      g.f.phy_areset       = phy_areset_o;
      check_ctrl("mac control fields", g, x);
    end
    write_reg(`MGT_REG_MAC_CTRL_STATUS, 32'h0);
    report_test("mac control", e0);
  endtask

  task automatic status_word_sweep();
    int          e0, i;
    logic [31:0] d, d2;
    logic [15:0] prev;
    bit          ok;
    mac_status_u st;
    e0 = errors;
    for (i = 0; i < 8; i++) begin
      @(posedge bus_clk);
      channel_up_i       <= 1'($urandom);
      hard_err_i         <= 1'($urandom);
      soft_err_i         <= 1'($urandom);
      gt_pll_lock_i      <= 1'($urandom);
      qpll_reset_i       <= 1'($urandom);
      qpll_lock_i        <= 1'($urandom);
      qpll_refclk_lost_i <= 1'($urandom);
      bist_locked_i      <= 1'($urandom);
      settle();
      read_reg(`MGT_REG_MAC_CTRL_STATUS, 1'b1, d, ok);
      st.raw = d;
      if (ok) check_mac_status("mac status", st, model_status(1'b0));
      read_reg(`MGT_REG_PHY_STATUS, 1'b1, d, ok);
      if (ok) check_word("phy status", d, model_phy_status());
    end
    // Checker hunting for lock
    @(posedge bus_clk);
    bist_locked_i <= 1'b0;
    write_reg(`MGT_REG_MAC_CTRL_STATUS, 32'h1);
    prev = '0;
    for (i = 0; i < 6; i++) begin
      repeat (10 + ($urandom % 20)) @(posedge bus_clk);
      read_reg(`MGT_REG_MAC_CTRL_STATUS, 1'b1, d, ok);
      st.raw = d;
      if (ok && st.f.lock_latency < prev)
        check_word("lock latency decreased", {16'd0, st.f.lock_latency}, {16'd0, prev});
      if (ok) prev = st.f.lock_latency;
    end
    if (prev == '0) check_word("lock latency never advanced", 32'd0, 32'd1);
    @(posedge bus_clk);
    bist_locked_i <= 1'b1;
    settle();
    read_reg(`MGT_REG_MAC_CTRL_STATUS, 1'b1, d, ok);
    repeat (20 + ($urandom % 30)) @(posedge bus_clk);   // Longer than one latency unit
    read_reg(`MGT_REG_MAC_CTRL_STATUS, 1'b1, d2, ok);
    if (ok) check_word("lock latency after lock", d2, d);
    write_reg(`MGT_REG_MAC_CTRL_STATUS, 32'h0);
    bist_locked_i <= 1'b0;
    report_test("status words", e0);
  endtask

  task automatic counter_readback();
    int          e0, i;
    logic [31:0] ovr, csum, d;
    logic [47:0] samps, errs;
    bit          ok;
    e0 = errors;
    for (i = 0; i < 5; i++) begin
      ovr   = $urandom;
      csum  = $urandom;
      samps = {16'($urandom), $urandom};
      errs  = {16'($urandom), $urandom};
      @(posedge bus_clk);
      overruns_i        <= ovr;
      checksum_errors_i <= csum;
      bist_samps_i      <= samps;
      bist_errors_i     <= errs;
      read_reg(`MGT_REG_OVERRUNS, 1'b1, d, ok);
      if (ok) check_word("overruns", d, ovr);
      read_reg(`MGT_REG_CHECKSUM_ERRORS, 1'b1, d, ok);
      if (ok) check_word("checksum errors", d, csum);
      read_reg(`MGT_REG_BIST_SAMPS, 1'b1, d, ok);
      if (ok) check_word("bist samples", d, samps[47:16]);
      read_reg(`MGT_REG_BIST_ERRORS, 1'b1, d, ok);
      if (ok) check_word("bist errors", d, errs[31:0]);
    end
    // Everything from 0x30 upward is outside the map
    read_reg(14'(14'h30 + ($urandom % 32'h3FD0)), 1'b0, d, ok);
    report_test("counters", e0);
  endtask

  task automatic crit_err_latch();
    int          e0;
    logic [31:0] d;
    bit          ok;
    mac_status_u st;
    e0 = errors;
    @(posedge bus_clk);
    crit_err_i <= 1'b1;
    repeat (3 + ($urandom % 4)) @(posedge bus_clk);
    crit_err_i <= 1'b0;
    settle();
    read_reg(`MGT_REG_MAC_CTRL_STATUS, 1'b1, d, ok);
    st.raw = d;
    if (ok) check_mac_status("critical error set", st, model_status(1'b1));
    write_reg(`MGT_REG_MAC_CTRL_STATUS, 32'h400);   // mac_clear
    settle();
    read_reg(`MGT_REG_MAC_CTRL_STATUS, 1'b1, d, ok);
    st.raw = d;
    if (ok) check_mac_status("critical error cleared", st, model_status(1'b0));
    write_reg(`MGT_REG_MAC_CTRL_STATUS, 32'h0);
    settle();
    read_reg(`MGT_REG_MAC_CTRL_STATUS, 1'b1, d, ok);
    st.raw = d;
    if (ok) check_mac_status("critical error stays clear", st, model_status(1'b0));
    report_test("critical error", e0);
  endtask

  task automatic pulse_beat(input bit on_tx);
    @(posedge bus_clk);
    if (on_tx) begin
      tx_valid_i <= 1'b1;
      tx_ready_i <= 1'b1;
    end else begin
      rx_valid_i <= 1'b1;
      rx_ready_i <= 1'b1;
    end
    @(posedge bus_clk);
    tx_valid_i <= 1'b0;
    tx_ready_i <= 1'b0;
    rx_valid_i <= 1'b0;
    rx_ready_i <= 1'b0;
  endtask

  task automatic activity_stretching();
    int          e0, i;
    logic [31:0] d;
    bit          ok;
    e0 = errors;
    @(posedge bus_clk);
    channel_up_i <= 1'b1;
    settle();
    for (i = 0; i < 4; i++) begin
      pulse_beat(1'($urandom));
      read_reg(`MGT_REG_PORT_INFO, 1'b1, d, ok);
      if (ok) check_word("activity after beat", d, port_info_word(1'b1, 1'b1));
      check_level("activity_o after beat", activity_o, 1'b1);
      check_level("link_up_o with link up", link_up_o, 1'b1);
      repeat (20 + ($urandom % 8)) @(posedge bus_clk);
      read_reg(`MGT_REG_PORT_INFO, 1'b1, d, ok);
      if (ok) check_word("activity after quiet", d, port_info_word(1'b1, 1'b0));
      check_level("activity_o after quiet", activity_o, 1'b0);
    end
    @(posedge bus_clk);
    channel_up_i <= 1'b0;
    settle();
    for (i = 0; i < 4; i++) begin
      pulse_beat(1'($urandom));
      read_reg(`MGT_REG_PORT_INFO, 1'b1, d, ok);
      if (ok) check_word("activity with link down", d, port_info_word(1'b0, 1'b0));
      check_level("activity_o with link down", activity_o, 1'b0);
      check_level("link_up_o with link down", link_up_o, 1'b0);
    end
    report_test("activity", e0);
  endtask

  // ----------------------------------------
  // Main sequence
  // ----------------------------------------
  initial begin
    int n;
    void'($urandom(32'had9c));
    errors = 0;
    checks = 0;
    tests  = 0;
    {wr_req_i, rd_req_i, channel_up_i, hard_err_i, soft_err_i, crit_err_i} <= '0;
    {gt_pll_lock_i, qpll_reset_i, qpll_lock_i, qpll_refclk_lost_i, bist_locked_i} <= '0;
    {tx_valid_i, tx_ready_i, rx_valid_i, rx_ready_i} <= '0;
    {wr_addr_i, rd_addr_i, wr_data_i} <= '0;
    {overruns_i, checksum_errors_i, bist_samps_i, bist_errors_i} <= '0;
    for (n = 0; n < 20 && bus_rst !== 1'b0; n++) @(negedge bus_clk);
    if (bus_rst !== 1'b0) begin
      $display("Reset was never released, stopping the run");
      $display("Test failed");
      $finish;
    end else begin
      port_info_readback();
      mac_ctrl_writes();
      status_word_sweep();
      counter_readback();
      crit_err_latch();
      activity_stretching();
      $display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
      if (errors == 0) begin
        $display("Test completed successfully");
      end else begin
        $display("Test failed");
      end
      $finish;
    end
  end

endmodule

// ==== testbench/tb_clk_gen.sv ====
// Testbench clock and reset source, instantiated once by the top-level testbench
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int RST_CYCLES = 5
)(
  output logic bus_clk,
  output logic bus_rst
);

  initial begin
    bus_clk = 1'b0;
    forever #10 bus_clk = ~bus_clk;   // 20 ns period
  end

  // Reset held over the first few rising edges
  initial begin
    bus_rst = 1'b1;
    repeat (RST_CYCLES) @(posedge bus_clk);
    bus_rst <= 1'b0;
  end

endmodule

// ==== logic/mgt_ctrl_core.sv ====
// Top of the bus-clock control and status block for an Aurora serial-link port
`timescale 1ns/1ps
`include "mgt_regs_defines.svh"

module mgt_ctrl_core #(
  parameter logic [`MGT_REG_AWIDTH-1:0] REG_BASE = '0,
  parameter logic [7:0]                 PORTNUM  = 8'd0
)(
  input  logic                           bus_clk,
  input  logic                           bus_rst,
  // Register port
  input  logic                           wr_req_i,
  input  logic [`MGT_REG_AWIDTH-1:0]     wr_addr_i,
  input  logic [`MGT_REG_DWIDTH-1:0]     wr_data_i,
  input  logic                           rd_req_i,
  input  logic [`MGT_REG_AWIDTH-1:0]     rd_addr_i,
  output logic                           rd_resp_o,
  output logic [`MGT_REG_DWIDTH-1:0]     rd_data_o,
  // Link status
  input  logic                           channel_up_i,
  input  logic                           hard_err_i,
  input  logic                           soft_err_i,
  input  logic                           crit_err_i,
  input  logic                           gt_pll_lock_i,
  input  logic                           qpll_reset_i,
  input  logic                           qpll_lock_i,
  input  logic                           qpll_refclk_lost_i,
  input  logic                           bist_locked_i,
  // Counters, already on bus_clk
  input  logic [`MGT_REG_DWIDTH-1:0]     overruns_i,
  input  logic [`MGT_REG_DWIDTH-1:0]     checksum_errors_i,
  input  logic [`MGT_BIST_CNT_WIDTH-1:0] bist_samps_i,
  input  logic [`MGT_BIST_CNT_WIDTH-1:0] bist_errors_i,
  // Stream handshakes
  input  logic                           tx_valid_i,
  input  logic                           tx_ready_i,
  input  logic                           rx_valid_i,
  input  logic                           rx_ready_i,
  // Control fields for the BIST generator and PHY
  output logic                           bist_gen_en_o,
  output logic [5:0]                     bist_gen_rate_o,
  output logic                           bist_loopback_en_o,
  output logic                           phy_areset_o,
  output logic                           link_up_o,
  output logic                           activity_o
);

  import mgt_regs_pkg::*;

  mac_ctrl_u                  mac_ctrl;
  mac_status_u                mac_status;
  logic [`MGT_REG_DWIDTH-1:0] phy_status;
  logic                       link_up;
  logic                       activity;

  ctrl_regs #(.REG_BASE(REG_BASE)) ctrl_regs_i (
    .bus_clk, .bus_rst, .wr_req_i, .wr_addr_i, .wr_data_i,
    .mac_ctrl_o (mac_ctrl)
  );

  status_capture status_capture_i (
    .bus_clk, .bus_rst, .channel_up_i, .hard_err_i, .soft_err_i, .crit_err_i,
    .gt_pll_lock_i, .qpll_reset_i, .qpll_lock_i, .qpll_refclk_lost_i, .bist_locked_i,
    .mac_ctrl_i   (mac_ctrl),
    .mac_status_o (mac_status),
    .phy_status_o (phy_status),
    .link_up_o    (link_up)
  );

  regport_readback #(.REG_BASE(REG_BASE), .PORTNUM(PORTNUM)) regport_readback_i (
    .bus_clk, .bus_rst, .rd_req_i, .rd_addr_i,
    .mac_status_i (mac_status),
    .phy_status_i (phy_status),
    .link_up_i    (link_up),
    .activity_i   (activity),
    .overruns_i, .checksum_errors_i, .bist_samps_i, .bist_errors_i,
    .rd_resp_o, .rd_data_o
  );

  activity_stretch activity_stretch_i (
    .bus_clk, .bus_rst,
    .link_up_i  (link_up),
    .tx_valid_i, .tx_ready_i, .rx_valid_i, .rx_ready_i,
    .activity_o (activity)
  );

  // Control fields straight off the register
  assign bist_gen_en_o      = mac_ctrl.f.bist_gen_en;
  assign bist_gen_rate_o    = mac_ctrl.f.bist_gen_rate;
  assign bist_loopback_en_o = mac_ctrl.f.bist_loopback_en;
  assign phy_areset_o       = mac_ctrl.f.phy_areset;
  assign link_up_o          = link_up;
  assign activity_o         = activity;

endmodule

// ==== logic/activity_stretch.sv ====
// Stretches stream handshake beats into an activity level for the port LED
`timescale 1ns/1ps
`include "mgt_regs_defines.svh"

module activity_stretch (
  input  logic bus_clk,
  input  logic bus_rst,
  input  logic link_up_i,
  input  logic tx_valid_i,
  input  logic tx_ready_i,
  input  logic rx_valid_i,
  input  logic rx_ready_i,
  output logic activity_o
);

  localparam int unsigned CNT_W = $clog2(`MGT_ACT_STRETCH + 1);
  localparam logic [CNT_W-1:0] STRETCH_LOAD = `MGT_ACT_STRETCH;

  logic             beat;
  logic [CNT_W-1:0] stretch_cnt_q;

  // A beat on either stream
  assign beat = (tx_valid_i && tx_ready_i) || (rx_valid_i && rx_ready_i);

  // ----------------------------------------
  // Down-counter, held at zero with no link
  // ----------------------------------------
  always_ff @(posedge bus_clk) begin
    if (bus_rst || !link_up_i) begin
      stretch_cnt_q <= '0;
    end else if (beat) begin
      stretch_cnt_q <= STRETCH_LOAD;    // Restart on every beat
    end else if (stretch_cnt_q != '0) begin
      stretch_cnt_q <= stretch_cnt_q - 1'b1;
    end
  end

  assign activity_o = (stretch_cnt_q != '0);

endmodule

// ==== logic/regport_readback.sv ====
// Registered read decoder returning port info, status and counter words
`timescale 1ns/1ps
`include "mgt_regs_defines.svh"

module regport_readback #(
  parameter logic [`MGT_REG_AWIDTH-1:0] REG_BASE = '0,
  parameter logic [7:0]                 PORTNUM  = 8'd0
)(
  input  logic                           bus_clk,
  input  logic                           bus_rst,
  input  logic                           rd_req_i,
  input  logic [`MGT_REG_AWIDTH-1:0]     rd_addr_i,
  input  mgt_regs_pkg::mac_status_u      mac_status_i,
  input  logic [`MGT_REG_DWIDTH-1:0]     phy_status_i,
  input  logic                           link_up_i,
  input  logic                           activity_i,
  input  logic [`MGT_REG_DWIDTH-1:0]     overruns_i,
  input  logic [`MGT_REG_DWIDTH-1:0]     checksum_errors_i,
  input  logic [`MGT_BIST_CNT_WIDTH-1:0] bist_samps_i,
  input  logic [`MGT_BIST_CNT_WIDTH-1:0] bist_errors_i,
  output logic                           rd_resp_o,
  output logic [`MGT_REG_DWIDTH-1:0]     rd_data_o
);

  localparam logic [`MGT_REG_AWIDTH-1:0] A_PORT_INFO = REG_BASE + `MGT_REG_PORT_INFO;
  localparam logic [`MGT_REG_AWIDTH-1:0] A_MAC_STAT  = REG_BASE + `MGT_REG_MAC_CTRL_STATUS;
  localparam logic [`MGT_REG_AWIDTH-1:0] A_PHY_STAT  = REG_BASE + `MGT_REG_PHY_STATUS;
  localparam logic [`MGT_REG_AWIDTH-1:0] A_OVERRUNS  = REG_BASE + `MGT_REG_OVERRUNS;
  localparam logic [`MGT_REG_AWIDTH-1:0] A_CSUM_ERR  = REG_BASE + `MGT_REG_CHECKSUM_ERRORS;
  localparam logic [`MGT_REG_AWIDTH-1:0] A_BIST_SAMP = REG_BASE + `MGT_REG_BIST_SAMPS;
  localparam logic [`MGT_REG_AWIDTH-1:0] A_BIST_ERR  = REG_BASE + `MGT_REG_BIST_ERRORS;

  logic                       addr_hit;
  logic                       rd_accept;
  logic [`MGT_REG_DWIDTH-1:0] rd_word;
  logic                       rd_resp_q;
  logic [`MGT_REG_DWIDTH-1:0] rd_data_q;

  // ----------------------------------------
  // Address decode
  // ----------------------------------------
  always_comb begin
    addr_hit = 1'b1;
    case (rd_addr_i)
      A_PORT_INFO: rd_word = {`MGT_COMPAT_NUM, 6'h0, activity_i, link_up_i,
                              `MGT_PROTOCOL_AURORA, PORTNUM};
      A_MAC_STAT:  rd_word = mac_status_i.raw;
      A_PHY_STAT:  rd_word = phy_status_i;
      A_OVERRUNS:  rd_word = overruns_i;
      A_CSUM_ERR:  rd_word = checksum_errors_i;
      A_BIST_SAMP: rd_word = bist_samps_i[`MGT_BIST_CNT_WIDTH-1 -: `MGT_REG_DWIDTH];  // /2^16
      A_BIST_ERR:  rd_word = bist_errors_i[`MGT_REG_DWIDTH-1:0];
      default: begin
        addr_hit = 1'b0;   // Unmapped, stay silent
        rd_word  = '0;
      end
    endcase
  end

  // A request landing on a response cycle is dropped
  assign rd_accept = rd_req_i && addr_hit && !rd_resp_q;

  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      rd_resp_q <= 1'b0;
    end else begin
      rd_resp_q <= rd_accept;
    end
  end

  always_ff @(posedge bus_clk) begin
    if (rd_accept) rd_data_q <= rd_word;
  end

  assign rd_resp_o = rd_resp_q;
  assign rd_data_o = rd_data_q;

  a_single_resp: assert property (@(posedge bus_clk) disable iff (bus_rst)
                                  rd_resp_o |=> !rd_resp_o)
    else $error("read response held for two cycles");

endmodule

// ==== logic/status_capture.sv ====
// Brings link status into the bus clock domain and builds the MAC and PHY status words
`timescale 1ns/1ps
`include "mgt_regs_defines.svh"

module status_capture (
  input  logic                       bus_clk,
  input  logic                       bus_rst,
  // Levels from the link clock domain
  input  logic                       channel_up_i,
  input  logic                       hard_err_i,
  input  logic                       soft_err_i,
  input  logic                       crit_err_i,
  input  logic                       gt_pll_lock_i,
  // Reported as they come
  input  logic                       qpll_reset_i,
  input  logic                       qpll_lock_i,
  input  logic                       qpll_refclk_lost_i,
  input  logic                       bist_locked_i,
  input  mgt_regs_pkg::mac_ctrl_u    mac_ctrl_i,
  output mgt_regs_pkg::mac_status_u  mac_status_o,
  output logic [`MGT_REG_DWIDTH-1:0] phy_status_o,
  output logic                       link_up_o
);

  import mgt_regs_pkg::*;

  // Bit positions in the synchronizer vector
  localparam int unsigned S_CHAN = 0;
  localparam int unsigned S_HERR = 1;
  localparam int unsigned S_SERR = 2;
  localparam int unsigned S_CERR = 3;
  localparam int unsigned S_PLL  = 4;

  logic [4:0]                     async_lvl;
  logic [4:0]                     sync_meta_q;
  logic [4:0]                     sync_q;
  logic [`MGT_LOCK_LAT_WIDTH-1:0] lock_lat_q;
  logic                           crit_err_q;
  logic                           checker_en;
  logic                           mac_clear;
  mac_status_u                    status_w;

  assign checker_en = mac_ctrl_i.f.bist_checker_en;
  assign mac_clear  = mac_ctrl_i.f.mac_clear;

  assign async_lvl = {gt_pll_lock_i, crit_err_i, soft_err_i, hard_err_i, channel_up_i};

  // ----------------------------------------
  // Two-flop synchronizers
  // ----------------------------------------
  always_ff @(posedge bus_clk) begin
    sync_meta_q <= async_lvl;
    sync_q      <= sync_meta_q;
  end

  // BIST lock latency, frozen once the checker locks
  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      lock_lat_q <= '0;
    end else if (!checker_en && !bist_locked_i) begin
      lock_lat_q <= '0;
    end else if (checker_en && !bist_locked_i) begin
      lock_lat_q <= lock_lat_q + 1'b1;
    end
  end

  // Sticky critical error
  always_ff @(posedge bus_clk) begin
    if (bus_rst || mac_clear) begin
      crit_err_q <= 1'b0;
    end else if (sync_q[S_CERR]) begin
      crit_err_q <= 1'b1;
    end
  end

  // ----------------------------------------
  // Status words
  // ----------------------------------------
  always_comb begin
    status_w                    = '0;
    status_w.f.channel_up       = sync_q[S_CHAN];
    status_w.f.hard_err         = sync_q[S_HERR];
    status_w.f.soft_err         = sync_q[S_SERR];
    status_w.f.bist_locked      = bist_locked_i;
    status_w.f.lock_latency     = lock_lat_q[`MGT_LOCK_LAT_WIDTH-1:4];  // 16-cycle units
    status_w.f.qpll_reset       = qpll_reset_i;
    status_w.f.qpll_lock        = qpll_lock_i;
    status_w.f.qpll_refclk_lost = qpll_refclk_lost_i;
    status_w.f.gt_pll_lock      = sync_q[S_PLL];
    status_w.f.const_one        = 1'b1;
    status_w.f.crit_err         = crit_err_q;
  end

  assign mac_status_o = status_w;
  assign phy_status_o = {30'd0, hard_err_i, channel_up_i};  // Raw levels, as on hardware
  assign link_up_o    = sync_q[S_CHAN];

  property p_crit_err_sticky;
    @(posedge bus_clk) disable iff (bus_rst)
      $fell(crit_err_q) |-> $past(bus_rst || mac_clear);
  endproperty

  a_crit_err_sticky: assert property (p_crit_err_sticky)
    else $error("critical error flag cleared without reset or mac_clear");

endmodule

// ==== logic/ctrl_regs.sv ====
// Write decoder holding the MAC control register of the link port
`timescale 1ns/1ps
`include "mgt_regs_defines.svh"

module ctrl_regs #(
  parameter logic [`MGT_REG_AWIDTH-1:0] REG_BASE = '0
)(
  input  logic                       bus_clk,
  input  logic                       bus_rst,
  input  logic                       wr_req_i,
  input  logic [`MGT_REG_AWIDTH-1:0] wr_addr_i,
  input  logic [`MGT_REG_DWIDTH-1:0] wr_data_i,
  output mgt_regs_pkg::mac_ctrl_u    mac_ctrl_o
);

  import mgt_regs_pkg::*;

  localparam logic [`MGT_REG_AWIDTH-1:0] MAC_CTRL_ADDR = REG_BASE + `MGT_REG_MAC_CTRL_STATUS;

  mac_ctrl_u mac_ctrl_q;
  logic      ctrl_wr_hit;

  assign ctrl_wr_hit = wr_req_i && (wr_addr_i == MAC_CTRL_ADDR);

  // ----------------------------------------
  // Control register
  // ----------------------------------------
  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      mac_ctrl_q.raw <= '0;   // Aurora resets with everything off
    end else if (ctrl_wr_hit) begin
      mac_ctrl_q.raw <= wr_data_i;
    end
  end

  assign mac_ctrl_o = mac_ctrl_q;

  // Fields downstream only move on a control write or out of reset
  property p_ctrl_only_on_write;
    @(posedge bus_clk) disable iff (bus_rst)
      !$stable(mac_ctrl_q.raw) |-> ($past(ctrl_wr_hit) || $past(bus_rst));
  endproperty

  a_ctrl_only_on_write: assert property (p_ctrl_only_on_write)
    else $error("mac_ctrl changed without a control write");

endmodule

// ==== logic/mgt_regs_pkg.sv ====
// Register word layouts for MAC control and MAC status, used by the RTL and the testbench
package mgt_regs_pkg;

  // MAC control word, written raw and read back by field
  typedef union packed {
    logic [31:0] raw;
    struct packed {
      logic [20:0] reserved;          // [31:11]
      logic        mac_clear;         // [10]
      logic        phy_areset;        // [9]
      logic [5:0]  bist_gen_rate;     // [8:3]
      logic        bist_loopback_en;  // [2]
      logic        bist_gen_en;       // [1]
      logic        bist_checker_en;   // [0]
    } f;
  } mac_ctrl_u;

  // MAC status word, built by field and read back raw
  typedef union packed {
    logic [31:0] raw;
    struct packed {
      logic [5:0]  zero;              // [31:26]
      logic        crit_err;          // [25]
      logic        const_one;         // [24]
      logic        gt_pll_lock;       // [23]
      logic        qpll_refclk_lost;  // [22]
      logic        qpll_lock;         // [21]
      logic        qpll_reset;        // [20]
      logic [15:0] lock_latency;      // [19:4]
      logic        bist_locked;       // [3]
      logic        soft_err;          // [2]
      logic        hard_err;          // [1]
      logic        channel_up;        // [0]
    } f;
  } mac_status_u;

endpackage

// ==== logic/mgt_regs_defines.svh ====
// Register map, widths and constants shared by the link control block and its testbench
`ifndef MGT_REGS_DEFINES_SVH
`define MGT_REGS_DEFINES_SVH

// ----------------------------------------
// Register port geometry
// ----------------------------------------
`define MGT_REG_DWIDTH 32
`define MGT_REG_AWIDTH 14

// Offsets from REG_BASE
`define MGT_REG_PORT_INFO       14'h0
`define MGT_REG_MAC_CTRL_STATUS 14'h4   // Ctrl on write, status on read
`define MGT_REG_PHY_STATUS      14'h8
`define MGT_REG_OVERRUNS        14'h20
`define MGT_REG_CHECKSUM_ERRORS 14'h24
`define MGT_REG_BIST_SAMPS      14'h28
`define MGT_REG_BIST_ERRORS     14'h2C

// ----------------------------------------
// Port info constants
// ----------------------------------------
`define MGT_COMPAT_NUM      8'd1
`define MGT_PROTOCOL_AURORA 8'd3

// Datapath widths
`define MGT_BIST_CNT_WIDTH 48
`define MGT_LOCK_LAT_WIDTH 20

`define MGT_ACT_STRETCH 16    // Cycles of activity after last beat

`endif
